//--- Makefile
# Verilator build and run of the hazard core testbench

VERILATOR ?= verilator
TOP       ?= hazardCoreTb
FILELIST  ?= hazardCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= TEST PASS

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)

test: build
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hazardCore.f
+incdir+tests
hw/isaPkg.sv
hw/pipePkg.sv
hw/instrDecoder.sv
hw/stageRegs.sv
hw/hazardUnit.sv
hw/hazardCore.sv
tests/hazardCoreTb.sv

//--- hw/hazardCore.sv
// Top level of the hazard-control slice of the five-stage pipeline
// fetched words go in, forwarding/stall/flush controls and the writeback strobe come out

`default_nettype none

module hazardCore (
	input  logic             clk,
	input  logic             rst,
	input  isaPkg::instrT    instrIn,
	input  logic             brTaken,
	output pipePkg::hazardT  hazard,
	output logic             wbWrite,
	output isaPkg::regAddrT  wbReg
);

	// word sitting in decode
	isaPkg::instrT decInstr;
	// decoded control of that word
	pipePkg::decodeCtrlT decCtrl;
	// stage control further down the pipe
	pipePkg::stageCtrlT exCtrl;
	pipePkg::stageCtrlT memCtrl;
	pipePkg::stageCtrlT wbCtrl;

	// pipeline registers, steered by the hazard outputs
	stageRegs u_stageRegs (
		.clk      (clk),
		.rst      (rst),
		.instrIn  (instrIn),
		.decCtrl  (decCtrl),
		.hazard   (hazard),
		.decInstr (decInstr),
		.exCtrl   (exCtrl),
		.memCtrl  (memCtrl),
		.wbCtrl   (wbCtrl)
	);

	// combinational decode of the decode-stage word
	instrDecoder u_decoder (
		.instr (decInstr),
		.ctrl  (decCtrl)
	);

	// compares decode tags against the later stages
	hazardUnit u_hazard (
		.decCtrl (decCtrl),
		.brTaken (brTaken),
		.exCtrl  (exCtrl),
		.memCtrl (memCtrl),
		.wbCtrl  (wbCtrl),
		.hazard  (hazard)
	);

	// register file write port
	assign wbWrite = wbCtrl.regWrite;
	assign wbReg   = wbCtrl.writeReg;

endmodule

`default_nettype wire

//--- hw/hazardUnit.sv
// Hazard unit for the five-stage pipeline
// forwarding selects, load-use and branch stalls, decode and execute flushes

`default_nettype none

module hazardUnit (
	input  pipePkg::decodeCtrlT decCtrl,
	input  logic                brTaken,
	input  pipePkg::stageCtrlT  exCtrl,
	input  pipePkg::stageCtrlT  memCtrl,
	input  pipePkg::stageCtrlT  wbCtrl,
	output pipePkg::hazardT     hazard
);

	logic loadStall;
	logic branchStall;
	logic anyStall;
	// decode wants its operands now, either as a branch compare or a jalr target
	logic decRead;

	// execute operand source, memory stage has the newer value
	function automatic logic [1:0] exSelect(
		input isaPkg::regAddrT    src,
		input pipePkg::stageCtrlT mem,
		input pipePkg::stageCtrlT wb
	);
		logic [1:0] sel;
		if ((src != '0) && (src == mem.writeReg) && mem.regWrite) begin
			sel = pipePkg::fwdMem;
		end else if ((src != '0) && (src == wb.writeReg) && wb.regWrite) begin
			sel = pipePkg::fwdWb;
		end else begin
			sel = pipePkg::fwdNone;
		end
		return sel;
	endfunction

	// destination matches either decode source
	function automatic logic readsDest(
		input isaPkg::regAddrT dest,
		input isaPkg::regAddrT rs,
		input isaPkg::regAddrT rt
	);
		return (dest == rs) || (dest == rt);
	endfunction

	assign decRead = decCtrl.branch | decCtrl.jalr;

	always_comb begin
		// execute bypass, both operands
		hazard.forwardAE = exSelect(exCtrl.rs, memCtrl, wbCtrl);
		hazard.forwardBE = exSelect(exCtrl.rt, memCtrl, wbCtrl);

		// decode bypass only from memory
		// writeback is covered by the register file writing in the first half
		hazard.forwardAD = (decCtrl.stage.rs != '0) && memCtrl.regWrite &&
			(decCtrl.stage.rs == memCtrl.writeReg);
		hazard.forwardBD = (decCtrl.stage.rt != '0) && memCtrl.regWrite &&
			(decCtrl.stage.rt == memCtrl.writeReg);

		// load in execute feeding the next op, data not ready until writeback
		loadStall = exCtrl.memToReg &&
			readsDest(exCtrl.writeReg, decCtrl.stage.rs, decCtrl.stage.rt);

		// decode compare needs a result that is still in flight
		// ALU result in execute, or load data in memory
		branchStall = decRead && (
			(exCtrl.regWrite &&
				readsDest(exCtrl.writeReg, decCtrl.stage.rs, decCtrl.stage.rt)) ||
			(memCtrl.memToReg &&
				readsDest(memCtrl.writeReg, decCtrl.stage.rs, decCtrl.stage.rt)));

		anyStall = loadStall | branchStall;

		// hold fetch and decode, push a bubble into execute
		hazard.stallF = anyStall;
		hazard.stallD = anyStall;
		hazard.flushE = anyStall;

		// brTaken is not trusted while the compare is still waiting on data
		// j redirects unconditionally
		hazard.flushD = (brTaken & ~branchStall) | decCtrl.jump |
			(decCtrl.jalr & ~branchStall);
	end

	// 2'b11 has no source on the operand muxes
	fwdLegal: assert property (
		@(hazard) (hazard.forwardAE !== 2'b11) && (hazard.forwardBE !== 2'b11)
	);

	// stage registers rely on the bubble going in whenever decode holds
	stallFlushPair: assert property (
		@(hazard) hazard.flushE === hazard.stallD
	);

endmodule

`default_nettype wire

//--- hw/instrDecoder.sv
// Decode-stage control decoder
// turns the word held in the decode register into the control struct for that stage

`default_nettype none

module instrDecoder (
	input  isaPkg::instrT       instr,
	output pipePkg::decodeCtrlT ctrl
);

	// opcode sits in the same bits of both layouts
	logic [5:0] opcode;

	assign opcode = instr.r.opcode;

	always_comb begin
		ctrl = '0;
		// sources taken from the word even for ops that never read them
		// the hazard unit still compares them, like the original pipeline
		ctrl.stage.rs = instr.i.rs;
		ctrl.stage.rt = instr.i.rt;

		case (opcode)
			isaPkg::opRtype: begin
				// ALU op or jalr, result goes to rd
				ctrl.stage.rs       = instr.r.rs;
				ctrl.stage.rt       = instr.r.rt;
				ctrl.stage.writeReg = instr.r.rd;
				ctrl.stage.regWrite = 1'b1;
				// jalr reads rs in decode for its target
				ctrl.jalr = (instr.r.funct == isaPkg::fnJalr);
			end
			isaPkg::opAddi: begin
				// immediate op writes rt
				ctrl.stage.writeReg = instr.i.rt;
				ctrl.stage.regWrite = 1'b1;
			end
			isaPkg::opLw: begin
				// load result only exists after memory
				ctrl.stage.writeReg = instr.i.rt;
				ctrl.stage.regWrite = 1'b1;
				ctrl.stage.memToReg = 1'b1;
			end
			isaPkg::opSw: begin
				// store reads rt as data, writes no register
				ctrl.stage.memWrite = 1'b1;
			end
			isaPkg::opBeq, isaPkg::opBne: begin
				// compare happens in decode, outcome comes back as brTaken
				ctrl.branch = 1'b1;
			end
			isaPkg::opJ: begin
				ctrl.jump = 1'b1;
			end
			default: begin
				// unknown opcode
				// only the source fields survive, the slot acts as a bubble
				ctrl.stage.writeReg = '0;
			end
		endcase

		// a write to r0 is dropped here
		// nopWord lands in this case too, being sll into r0
		if (ctrl.stage.writeReg == '0) begin
			ctrl.stage.regWrite = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/isaPkg.sv
// Instruction formats and encodings for the MIPS-style integer subset
// shared by the decoder, the pipeline types and the testbench stimulus

`default_nettype none

package isaPkg;

	// register index
	// index 0 is the hardwired zero register and is never a real destination
	typedef logic [4:0] regAddrT;

	// R-type layout, used by the ALU ops and by jalr
	typedef struct packed {
		logic [5:0] opcode;
		regAddrT    rs;
		regAddrT    rt;
		regAddrT    rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	// I-type layout
	// j only uses the opcode here, its target sits across rs, rt and imm
	typedef struct packed {
		logic [5:0]  opcode;
		regAddrT     rs;
		regAddrT     rt;
		logic [15:0] imm;
	} iTypeT;

	// one fetched word, read through whichever layout its opcode calls for
	// opcode, rs and rt line up in both views
	typedef union packed {
		rTypeT r;
		iTypeT i;
	} instrT;

	// primary opcodes
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opBne   = 6'h05;
	localparam logic [5:0] opAddi  = 6'h08;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// R-type funct codes
	// jalr writes the link into rd like any other R-type op
	localparam logic [5:0] fnJalr = 6'h09;
	localparam logic [5:0] fnAdd  = 6'h20;
	localparam logic [5:0] fnSub  = 6'h22;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	// all-zero word
	// decodes as sll r0, r0, 0, so it writes nothing and reads only r0
	localparam instrT nopWord = '0;

endpackage

`default_nettype wire

//--- hw/pipePkg.sv
// Pipeline control types passed between decoder, stage registers and hazard unit
// plus the forwarding select encoding that drives the operand muxes

`default_nettype none

package pipePkg;

	// control that follows an instruction from execute through writeback
	// rs and rt stay along so execute can pick its forwarding sources
	typedef struct packed {
		logic            regWrite;
		logic            memToReg;
		logic            memWrite;
		isaPkg::regAddrT rs;
		isaPkg::regAddrT rt;
		isaPkg::regAddrT writeReg;
	} stageCtrlT;

	// decode-stage view
	// the control-flow bits are resolved in decode and never travel further
	typedef struct packed {
		stageCtrlT stage;
		logic      branch;
		logic      jump;
		logic      jalr;
	} decodeCtrlT;

	// empty slot, identical to what a decoded nop carries minus its sources
	localparam stageCtrlT bubble = '0;

	// execute operand select
	// writeback result on 01, memory-stage ALU result on 10
	localparam logic [1:0] fwdNone = 2'b00;
	localparam logic [1:0] fwdWb   = 2'b01;
	localparam logic [1:0] fwdMem  = 2'b10;

	// everything the hazard unit hands back to the pipeline
	typedef struct packed {
		logic       forwardAD;
		logic       forwardBD;
		logic [1:0] forwardAE;
		logic [1:0] forwardBE;
		logic       stallF;
		logic       stallD;
		logic       flushD;
		logic       flushE;
	} hazardT;

endpackage

`default_nettype wire

//--- hw/stageRegs.sv
// Pipeline registers of the hazard core
// decode holds the raw word, execute/memory/writeback hold decoded stage control

`default_nettype none

module stageRegs (
	input  logic                clk,
	input  logic                rst,
	input  isaPkg::instrT       instrIn,
	input  pipePkg::decodeCtrlT decCtrl,
	input  pipePkg::hazardT     hazard,
	output isaPkg::instrT       decInstr,
	output pipePkg::stageCtrlT  exCtrl,
	output pipePkg::stageCtrlT  memCtrl,
	output pipePkg::stageCtrlT  wbCtrl
);

	// decode register
	// stall wins over flush, so a stalled branch keeps its slot
	always_ff @(posedge clk) begin
		if (rst) begin
			decInstr <= isaPkg::nopWord;
		end else if (hazard.stallD) begin
			decInstr <= decInstr;
		end else if (hazard.flushD) begin
			// squashed fetch slot turns into a nop
			decInstr <= isaPkg::nopWord;
		end else begin
			decInstr <= instrIn;
		end
	end

	// execute register
	// flushE rises together with stallD, so the held decode slot
	// is not copied forward twice
	always_ff @(posedge clk) begin
		if (rst) begin
			exCtrl <= pipePkg::bubble;
		end else if (hazard.flushE) begin
			exCtrl <= pipePkg::bubble;
		end else begin
			exCtrl <= decCtrl.stage;
		end
	end

	// memory and writeback never stall or flush
	always_ff @(posedge clk) begin
		if (rst) begin
			memCtrl <= pipePkg::bubble;
			wbCtrl  <= pipePkg::bubble;
		end else begin
			memCtrl <= exCtrl;
			wbCtrl  <= memCtrl;
		end
	end

	// a flushed execute slot must not write anything later on
	exBubble: assert property (
		@(posedge clk) disable iff (rst)
		hazard.flushE |=> !exCtrl.regWrite
	);

	// decoder drops r0 writes
	// nothing that reaches writeback may strobe register 0
	wbNoZero: assert property (
		@(posedge clk) disable iff (rst)
		wbCtrl.regWrite |-> (wbCtrl.writeReg != '0)
	);

endmodule

`default_nettype wire

//--- tests/hazardModel.svh
// Reference model of the hazard core for the testbench
// a shadow pipeline plus the expected hazard outputs, included at compilation-unit scope
`ifndef hazardModelSvh
`define hazardModelSvh

`default_nettype none

// shadow of the four pipeline registers
typedef struct packed {
	isaPkg::instrT      dec;
	pipePkg::stageCtrlT ex;
	pipePkg::stageCtrlT mem;
	pipePkg::stageCtrlT wb;
} shadowT;

// decode field rules, written from the ISA description
function automatic pipePkg::decodeCtrlT modelDecode(input isaPkg::instrT w);
	pipePkg::decodeCtrlT c;
	logic [5:0] op;
	op = w.i.opcode;
	c = '0;
	// sources always come straight from the word
	c.stage.rs = w.i.rs;
	c.stage.rt = w.i.rt;
	if (op == isaPkg::opRtype) begin
		c.stage.writeReg = w.r.rd;
		c.stage.regWrite = (w.r.rd != 5'd0);
		c.jalr = (w.r.funct == isaPkg::fnJalr);
	end else if ((op == isaPkg::opAddi) || (op == isaPkg::opLw)) begin
		c.stage.writeReg = w.i.rt;
		c.stage.regWrite = (w.i.rt != 5'd0);
		// load flag stays even for an r0 target
		c.stage.memToReg = (op == isaPkg::opLw);
	end else if (op == isaPkg::opSw) begin
		c.stage.memWrite = 1'b1;
	end else if ((op == isaPkg::opBeq) || (op == isaPkg::opBne)) begin
		c.branch = 1'b1;
	end else if (op == isaPkg::opJ) begin
		c.jump = 1'b1;
	end
	return c;
endfunction

// does a stage write the given nonzero register
function automatic logic writesReg(input pipePkg::stageCtrlT s, input isaPkg::regAddrT r);
	return s.regWrite && (r != 5'd0) && (s.writeReg == r);
endfunction

// expected hazard outputs for a shadow state and a brTaken level
function automatic pipePkg::hazardT expectHazard(input shadowT s, input logic br);
	pipePkg::hazardT h;
	pipePkg::decodeCtrlT d;
	logic loadStall;
	logic branchStall;
	logic exHit;
	logic memLoadHit;
	d = modelDecode(s.dec);
	h = '0;
	// memory stage wins over writeback
	h.forwardAE = writesReg(s.mem, s.ex.rs) ? pipePkg::fwdMem :
		(writesReg(s.wb, s.ex.rs) ? pipePkg::fwdWb : pipePkg::fwdNone);
	h.forwardBE = writesReg(s.mem, s.ex.rt) ? pipePkg::fwdMem :
		(writesReg(s.wb, s.ex.rt) ? pipePkg::fwdWb : pipePkg::fwdNone);
	h.forwardAD = writesReg(s.mem, d.stage.rs);
	h.forwardBD = writesReg(s.mem, d.stage.rt);
	loadStall = s.ex.memToReg &&
		((s.ex.writeReg == d.stage.rs) || (s.ex.writeReg == d.stage.rt));
	exHit = s.ex.regWrite &&
		((s.ex.writeReg == d.stage.rs) || (s.ex.writeReg == d.stage.rt));
	memLoadHit = s.mem.memToReg &&
		((s.mem.writeReg == d.stage.rs) || (s.mem.writeReg == d.stage.rt));
	branchStall = (d.branch || d.jalr) && (exHit || memLoadHit);
	h.stallF = loadStall || branchStall;
	h.stallD = h.stallF;
	h.flushE = h.stallF;
	h.flushD = (br && !branchStall) || d.jump || (d.jalr && !branchStall);
	return h;
endfunction

// one clock edge of the shadow pipeline, out of reset
function automatic shadowT nextShadow(input shadowT s, input isaPkg::instrT fetched,
		input logic br);
	shadowT n;
	pipePkg::hazardT h;
	pipePkg::decodeCtrlT d;
	h = expectHazard(s, br);
	d = modelDecode(s.dec);
	n.wb = s.mem;
	n.mem = s.ex;
	n.ex = h.flushE ? pipePkg::stageCtrlT'('0) : d.stage;
	// stall holds the slot, flush turns it into a nop
	n.dec = h.stallD ? s.dec : (h.flushD ? isaPkg::nopWord : fetched);
	return n;
endfunction

`default_nettype wire

`endif

//--- tests/hazardCoreTb.sv
// Testbench of the hazard core
// random instruction stream against a shadow pipeline, compared at every falling edge
`include "hazardModel.svh"

`default_nettype none

module hazardCoreTb;
	timeunit 1ns;
	timeprecision 1ps;

	// fetch slots driven after reset
	localparam int numInstr = 2000;
	localparam int drainCycles = 12;

	logic clk;
	logic rst;
	isaPkg::instrT instrIn;
	logic brTaken;
	pipePkg::hazardT hazard;
	logic wbWrite;
	isaPkg::regAddrT wbReg;

	shadowT shadow;
	pipePkg::hazardT expHaz;
	logic [31:0] rngState;
	int errorCount;
	int checkCount;
	// how often the interesting cases came up
	int stallSeen;
	int flushSeen;
	int fwdMemSeen;
	int wbSeen;

	hazardCore u_dut (
		.clk     (clk),
		.rst     (rst),
		.instrIn (instrIn),
		.brTaken (brTaken),
		.hazard  (hazard),
		.wbWrite (wbWrite),
		.wbReg   (wbReg)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	// weighted opcode, registers kept to r0..r7 so hazards pile up
	task automatic randomInstr(output isaPkg::instrT w);
		logic [31:0] pick;
		logic [31:0] f;
		rngState = xorshift(rngState);
		pick = rngState;
		rngState = xorshift(rngState);
		f = rngState;
		w = '0;
		w.i.rs = {2'b00, f[10:8]};
		w.i.rt = {2'b00, f[13:11]};
		// top five bits become rd in the R-type view
		w.i.imm = {2'b00, f[16:14], f[26:21], f[4:0]};
		case (pick[3:0])
			4'd0, 4'd1, 4'd2, 4'd3: begin
				w.r.opcode = isaPkg::opRtype;
				w.r.shamt = 5'd0;
				case (pick[6:4])
					3'd1: w.r.funct = isaPkg::fnSub;
					3'd2: w.r.funct = isaPkg::fnAnd;
					3'd3: w.r.funct = isaPkg::fnOr;
					3'd4: w.r.funct = isaPkg::fnSlt;
					default: w.r.funct = isaPkg::fnAdd;
				endcase
			end
			4'd4: begin
				w.r.opcode = isaPkg::opRtype;
				w.r.shamt = 5'd0;
				w.r.funct = isaPkg::fnJalr;
			end
			4'd5, 4'd6: w.i.opcode = isaPkg::opAddi;
			4'd7, 4'd8, 4'd9: w.i.opcode = isaPkg::opLw;
			4'd10: w.i.opcode = isaPkg::opSw;
			4'd11, 4'd12: w.i.opcode = isaPkg::opBeq;
			4'd13: w.i.opcode = isaPkg::opBne;
			4'd14: w.i.opcode = isaPkg::opJ;
			// unused opcode, should behave as a bubble
			default: w.i.opcode = 6'h3f;
		endcase
	endtask

	// new word unless fetch is stalled, brTaken only for a branch in decode
	task automatic driveSlot(input logic fresh);
		isaPkg::instrT w;
		pipePkg::hazardT h;
		pipePkg::decodeCtrlT d;
		h = expectHazard(shadow, 1'b0);
		d = modelDecode(shadow.dec);
		if (!h.stallF) begin
			if (fresh) begin
				randomInstr(w);
				instrIn = w;
			end else begin
				instrIn = isaPkg::nopWord;
			end
		end
		rngState = xorshift(rngState);
		brTaken = d.branch && rngState[7];
	endtask

	task automatic reportAndFinish();
		$display("checks %0d errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	// compare DUT against the shadow, then advance the shadow to the next edge
	always @(negedge clk) begin
		expHaz = expectHazard(shadow, brTaken);
		checkValue("forwardAD", 32'(expHaz.forwardAD), 32'(hazard.forwardAD));
		checkValue("forwardBD", 32'(expHaz.forwardBD), 32'(hazard.forwardBD));
		checkValue("forwardAE", 32'(expHaz.forwardAE), 32'(hazard.forwardAE));
		checkValue("forwardBE", 32'(expHaz.forwardBE), 32'(hazard.forwardBE));
		checkValue("stallF", 32'(expHaz.stallF), 32'(hazard.stallF));
		checkValue("stallD", 32'(expHaz.stallD), 32'(hazard.stallD));
		checkValue("flushD", 32'(expHaz.flushD), 32'(hazard.flushD));
		checkValue("flushE", 32'(expHaz.flushE), 32'(hazard.flushE));
		checkValue("wbWrite", 32'(shadow.wb.regWrite), 32'(wbWrite));
		checkValue("wbReg", 32'(shadow.wb.writeReg), 32'(wbReg));
		if (expHaz.stallD) stallSeen++;
		if (expHaz.flushD) flushSeen++;
		if (expHaz.forwardAE == pipePkg::fwdMem) fwdMemSeen++;
		if (shadow.wb.regWrite) wbSeen++;
		if (rst) begin
			shadow = '0;
		end else begin
			shadow = nextShadow(shadow, instrIn, brTaken);
		end
	end

	// run is bounded by the stimulus length plus slack for reset and drain
	initial begin
		#((numInstr + 50) * 100);
		$display("watchdog expired, the run timed out before the stimulus finished");
		errorCount++;
		reportAndFinish();
	end

	initial begin
		rst = 1'b1;
		instrIn = isaPkg::nopWord;
		brTaken = 1'b0;
		shadow = '0;
		rngState = 32'hef81c1ef;
		errorCount = 0;
		checkCount = 0;
		repeat (8) @(posedge clk);
		#5;
		rst = 1'b0;
		for (int slot = 0; slot < numInstr; slot++) begin
			driveSlot(1'b1);
			@(posedge clk);
			#5;
		end
		// let the last words retire
		repeat (drainCycles) begin
			driveSlot(1'b0);
			@(posedge clk);
			#5;
		end
		if ((stallSeen == 0) || (flushSeen == 0) || (fwdMemSeen == 0) || (wbSeen == 0)) begin
			$display("stimulus never produced a stall, a flush, a memory forward or a writeback");
			errorCount++;
		end
		reportAndFinish();
	end

endmodule

`default_nettype wire
